/* lsu_core.f */
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_stbuf.sv
verilog/lsu_dccm_ctl.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_core

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_addr_gen.sv
      - verilog/lsu_stbuf.sv
      - verilog/lsu_dccm_ctl.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/lsu_tb.sv

/* include/lsu_tb_tasks.svh */
// Load/store unit testbench tasks for response checks, reference model and directed tests
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
   end
endtask

// ******************************************************************
// Reference model
// ******************************************************************
function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_size_e size,
                                          input logic uns);
   logic [31:0] w;
   w = ref_mem[addr[DCCM_INDEX_BITS+1:2]] >> (8 * addr[1:0]);   // Addressed byte to bit 0
   case (size)
      SIZE_BYTE: return {{24{w[7] & ~uns}}, w[7:0]};
      SIZE_HALF: return {{16{w[15] & ~uns}}, w[15:0]};
      default:   return w;
   endcase
endfunction

function automatic logic [31:0] rand_word_addr();
   logic [31:0] r;
   r = $random(seed);
   return DCCM_BASE | {20'h0, r[DCCM_INDEX_BITS+1:2], 2'b00};
endfunction

// Drive one request and note what it must do
task automatic put_access(input logic st, input lsu_size_e size, input logic uns,
                          input logic [31:0] addr, input logic [31:0] data);
   logic [31:0]            r;
   logic [OFFSET_BITS-1:0] off;
   expect_t                e;
   int                     nbytes;
   r              = $random(seed);
   off            = r[OFFSET_BITS-1:0];
   req            = '0;
   req.ctl.valid  = 1'b1;
   req.ctl.load   = ~st;
   req.ctl.store  = st;
   req.ctl.size   = size;
   req.ctl.unsign = uns;
   req.offset     = off;
   req.base       = addr - {{(XLEN-OFFSET_BITS){off[OFFSET_BITS-1]}}, off};
   req.store_data = data;

   e            = '0;
   e.due        = cycles + 3;   // Result registered in dc3
   e.is_store   = st;
   e.addr       = addr;
   e.misaligned = (size == SIZE_HALF && addr[0]) || (size == SIZE_WORD && addr[1:0] != 2'b00);
   e.is_err     = e.misaligned || (addr[31:12] != DCCM_BASE[31:12]);   // 4 KiB window
   if (e.is_err || !st) begin
      if (!e.is_err) begin
         e.data = ref_load(addr, size, uns);
      end
      exp_q.push_back(e);
   end else begin
      nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
      for (int k = 0; k < nbytes; k++) begin
         ref_mem[addr[DCCM_INDEX_BITS+1:2]][8*(addr[1:0]+k) +: 8] = data[8*k +: 8];
      end
   end
endtask

// ******************************************************************
// Cycle stepping and response checks
// ******************************************************************
task automatic check_outputs();
   expect_t e;
   logic    due_now;
   e       = '0;
   due_now = (exp_q.size() > 0) && (exp_q[0].due == cycles);
   if (exp_q.size() > 0 && exp_q[0].due < cycles) begin
      stop_run("An expected load result or error packet never arrived");
   end else begin
      if (due_now) begin
         e = exp_q.pop_front();
      end
      check_val("load_result.valid", load_result.valid, due_now & ~e.is_err);
      check_val("error_pkt.exc_valid", error_pkt.exc_valid, due_now & e.is_err);
      check_val("misaligned_pulse", misaligned_pulse, due_now & e.misaligned);
      if (due_now && e.is_err) begin
         check_val("error_pkt.is_store", error_pkt.is_store, e.is_store);
         check_val("error_pkt.misaligned", error_pkt.misaligned, e.misaligned);
         check_val("error_pkt.addr", error_pkt.addr, e.addr);
      end else if (due_now) begin
         check_val("load_result.data", load_result.data, e.data);
      end
   end
endtask

task automatic next_cycle();
   @(negedge clk);
   check_outputs();
   req = '0;              // Strobe lasts one cycle
endtask

// Next free cycle, stores held back while store_stall is up
task automatic issue(input logic st, input lsu_size_e size, input logic uns,
                     input logic [31:0] addr, input logic [31:0] data);
   next_cycle();
   while (st && store_stall) begin
      next_cycle();
   end
   put_access(st, size, uns, addr, data);
endtask

task automatic wait_idle();
   next_cycle();
   while (!idle || exp_q.size() > 0) begin
      next_cycle();
   end
endtask

task automatic compare_mem();
   for (int i = 0; i < DCCM_WORDS; i++) begin
      check_val($sformatf("dccm_mem[%0d]", i), dccm_mem[i], ref_mem[i]);
   end
endtask

// ******************************************************************
// Directed tests
// ******************************************************************
task automatic reset_values();
   next_cycle();
   check_val("store_stall", store_stall, 0);
   check_val("idle", idle, 1);
   check_val("dccm_req.rden", dccm_req.rden, 0);
   check_val("dccm_req.wren", dccm_req.wren, 0);
endtask

task automatic word_round_trip();
   logic [31:0] a;
   for (int i = 0; i < 12; i++) begin
      a = rand_word_addr();
      issue(1'b1, SIZE_WORD, 1'b0, a, $random(seed));
      issue(1'b0, SIZE_WORD, 1'b0, a, '0);   // Served by forwarding
   end
   wait_idle();
   compare_mem();
endtask

task automatic subword_lanes();
   logic [31:0] a;
   logic [31:0] d;
   for (int w = 0; w < 3; w++) begin
      a = rand_word_addr();
      for (int off = 0; off < 4; off++) begin
         d    = $random(seed);
         d[7] = off[0];                  // Both sign polarities
         issue(1'b1, SIZE_BYTE, 1'b0, a + off, d);
         issue(1'b0, SIZE_BYTE, 1'b0, a + off, '0);
         issue(1'b0, SIZE_BYTE, 1'b1, a + off, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
         d     = $random(seed);
         d[15] = ~off[1];
         issue(1'b1, SIZE_HALF, 1'b0, a + off, d);
         issue(1'b0, SIZE_HALF, 1'b0, a + off, '0);
         issue(1'b0, SIZE_HALF, 1'b1, a + off, '0);
         issue(1'b0, SIZE_BYTE, 1'b0, a + off + 1, '0);
      end
      issue(1'b0, SIZE_WORD, 1'b0, a, '0);
   end
   wait_idle();
   compare_mem();
endtask

task automatic access_errors();
   logic [31:0] a;
   a = rand_word_addr();
   issue(1'b0, SIZE_HALF, 1'b0, a + 1, '0);
   issue(1'b1, SIZE_HALF, 1'b0, a + 3, 32'hDEAD_BEEF);
   issue(1'b0, SIZE_WORD, 1'b0, a + 2, '0);
   issue(1'b1, SIZE_WORD, 1'b0, a + 1, 32'hDEAD_BEEF);
   issue(1'b1, SIZE_WORD, 1'b0, DCCM_BASE + 32'h1000, 32'hDEAD_BEEF);   // Just past the DCCM
   issue(1'b0, SIZE_BYTE, 1'b1, DCCM_BASE - 1, '0);
   issue(1'b0, SIZE_WORD, 1'b0, 32'h0000_0100, '0);
   issue(1'b0, SIZE_WORD, 1'b0, a, '0);       // Good load right behind the errors
   wait_idle();
   compare_mem();
endtask

// Back-to-back stores into a four-word window, loads keep dc1 busy
task automatic stall_pressure();
   logic [31:0] a;
   logic [31:0] r;
   lsu_size_e   sz;
   logic [3:0]  boff;
   int          stores_left;
   int          since_load;
   int          stall_seen;
   logic        last_load;
   a           = rand_word_addr() & ~32'h0000_000F;
   stores_left = 24;
   since_load  = 0;
   stall_seen  = 0;
   last_load   = 1'b0;
   while (stores_left > 0) begin
      next_cycle();
      r    = $random(seed);
      sz   = (r[7:6] == 2'd0) ? SIZE_BYTE : (r[7:6] == 2'd1) ? SIZE_HALF : SIZE_WORD;
      boff = (sz == SIZE_BYTE) ? {r[5:4], r[3:2]} :
             (sz == SIZE_HALF) ? {r[5:4], r[3], 1'b0} : {r[5:4], 2'b00};
      if (store_stall) begin
         stall_seen++;
         if (!last_load) begin
            put_access(1'b0, sz, r[8], a + boff, '0);
         end
         last_load = ~last_load;         // Bubble every other cycle lets the buffer drain
      end else if (since_load == 2) begin
         put_access(1'b0, sz, r[8], a + boff, '0);
         since_load = 0;
         last_load  = 1'b1;
      end else begin
         put_access(1'b1, sz, 1'b0, a + boff, $random(seed));
         stores_left--;
         since_load++;
         last_load = 1'b0;
      end
   end
   wait_idle();
   if (stall_seen == 0) begin
      stop_run("store_stall never rose under back-to-back stores");
   end
   compare_mem();
endtask

`endif

/* dv/lsu_tb.sv */
// Load/store unit testbench with DCCM model, reference memory and directed tests
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;   // About ten times the whole test sequence
   localparam int DCCM_WORDS     = 2**DCCM_INDEX_BITS;

   typedef struct packed {
      logic [31:0] due;          // Cycle count at which the response shows
      logic        is_err;
      logic        is_store;
      logic        misaligned;
      logic [31:0] addr;
      logic [31:0] data;
   } expect_t;

   logic            clk;
   logic            rst_n;
   lsu_req_t        req;
   logic [XLEN-1:0] dccm_rd_data = '0;
   dccm_req_t       dccm_req;
   lsu_result_t     load_result;
   lsu_error_pkt_t  error_pkt;
   logic            misaligned_pulse;
   logic            store_stall;
   logic            idle;

   logic [XLEN-1:0] dccm_mem [DCCM_WORDS];
   logic [XLEN-1:0] ref_mem  [DCCM_WORDS];
   expect_t         exp_q [$];              // Loads and errors still to come
   int              cycles = 0;
   integer          seed   = 32'h971e;

   lsu_top dut_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .req              (req),
      .dccm_rd_data     (dccm_rd_data),
      .dccm_req         (dccm_req),
      .load_result      (load_result),
      .error_pkt        (error_pkt),
      .misaligned_pulse (misaligned_pulse),
      .store_stall      (store_stall),
      .idle             (idle)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Initial content, every word differs with its full index
   function automatic logic [31:0] fill_word(input int idx);
      return (idx * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
   endfunction

   // DCCM model, read data one edge after rden and byte-enabled writes
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DCCM_WORDS; i++) begin
            dccm_mem[i] <= fill_word(i);
         end
      end else begin
         if (dccm_req.rden) begin
            dccm_rd_data <= dccm_mem[dccm_req.rd_index];
         end
         if (dccm_req.wren) begin
            for (int b = 0; b < 4; b++) begin
               if (dccm_req.wr_byteen[b]) begin
                  dccm_mem[dccm_req.wr_index][8*b +: 8] <= dccm_req.wr_data[8*b +: 8];
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         stop_run($sformatf("Timeout, the run was still going after %0d cycles", cycles));
      end
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

`include "lsu_tb_tasks.svh"

   initial begin
      rst_n = 1'b0;
      req   = '0;
      for (int i = 0; i < DCCM_WORDS; i++) begin
         ref_mem[i] = fill_word(i);
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      reset_values();
      word_round_trip();
      subword_lanes();
      access_errors();
      stall_pressure();

      $display(">>> PASS");
      $finish;
   end

endmodule

/* verilog/lsu_top.sv */
// Load/store unit top level joining address generation, DCCM control and store buffer
`timescale 1ns/1ps

module lsu_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lsu_pkg::lsu_req_t        req,
   input  logic [lsu_pkg::XLEN-1:0] dccm_rd_data,
   output lsu_pkg::dccm_req_t       dccm_req,
   output lsu_pkg::lsu_result_t     load_result,
   output lsu_pkg::lsu_error_pkt_t  error_pkt,
   output logic                     misaligned_pulse,
   output logic                     store_stall,
   output logic                     idle
);
   import lsu_pkg::*;

   lsu_stage_t                 dc1, dc2, dc3;
   lsu_error_pkt_t             err_dc1;
   stbuf_fwd_t                 fwd;
   logic                       wr_valid;
   logic [DCCM_INDEX_BITS-1:0] wr_index;
   logic [XLEN-1:0]            wr_data;
   logic [3:0]                 wr_byteen;
   logic                       stbuf_stall;
   logic                       stbuf_empty;

   // ******************************************************************
   // Pipeline
   // ******************************************************************
   lsu_addr_gen addr_gen_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .dc1     (dc1),
      .err_dc1 (err_dc1)
   );

   lsu_dccm_ctl dccm_ctl_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .dc1              (dc1),
      .err_dc1          (err_dc1),
      .fwd              (fwd),
      .wr_valid         (wr_valid),
      .wr_index         (wr_index),
      .wr_data          (wr_data),
      .wr_byteen        (wr_byteen),
      .dccm_rd_data     (dccm_rd_data),
      .dc2              (dc2),
      .dc3              (dc3),
      .dccm_req         (dccm_req),
      .load_result      (load_result),
      .error_pkt        (error_pkt),
      .misaligned_pulse (misaligned_pulse)
   );

   lsu_stbuf stbuf_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .dc1       (dc1),
      .dc2       (dc2),
      .dc3       (dc3),
      .fwd       (fwd),
      .wr_valid  (wr_valid),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_byteen (wr_byteen),
      .stall     (stbuf_stall),
      .empty     (stbuf_empty)
   );

   // Stores only, loads keep flowing
   assign store_stall = stbuf_stall;

   // Nothing in flight and nothing left to write
   assign idle = ~(dc1.ctl.valid | dc2.ctl.valid | dc3.ctl.valid) & stbuf_empty;

endmodule

/* verilog/lsu_dccm_ctl.sv */
// Load/store DCCM control, read issue, dc2/dc3 pipeline and load data alignment
`timescale 1ns/1ps

module lsu_dccm_ctl (
   input  logic                                clk,
   input  logic                                rst_n,
   input  lsu_pkg::lsu_stage_t                 dc1,
   input  lsu_pkg::lsu_error_pkt_t             err_dc1,
   input  lsu_pkg::stbuf_fwd_t                 fwd,
   input  logic                                wr_valid,
   input  logic [lsu_pkg::DCCM_INDEX_BITS-1:0] wr_index,
   input  logic [lsu_pkg::XLEN-1:0]            wr_data,
   input  logic [3:0]                          wr_byteen,
   input  logic [lsu_pkg::XLEN-1:0]            dccm_rd_data,
   output lsu_pkg::lsu_stage_t                 dc2,
   output lsu_pkg::lsu_stage_t                 dc3,
   output lsu_pkg::dccm_req_t                  dccm_req,
   output lsu_pkg::lsu_result_t                load_result,
   output lsu_pkg::lsu_error_pkt_t             error_pkt,
   output logic                                misaligned_pulse
);
   import lsu_pkg::*;

   lsu_stage_t      dc2_q, dc3_q;          // Stage payload
   logic            dc2_vld, dc3_vld;
   lsu_error_pkt_t  err_dc2, err_dc3;
   logic [XLEN-1:0] merged;
   logic [XLEN-1:0] shifted;
   logic [XLEN-1:0] ld_data_dc2;
   logic [XLEN-1:0] ld_data_dc3;

   // DCCM port, read straight from dc1 and write from the store buffer
   always_comb begin
      dccm_req.rden      = dc1.ctl.valid & dc1.ctl.load;
      dccm_req.rd_index  = dc1.addr.f.index;
      dccm_req.wren      = wr_valid;
      dccm_req.wr_index  = wr_index;
      dccm_req.wr_data   = wr_data;
      dccm_req.wr_byteen = wr_byteen;
   end

   // ******************************************************************
   // dc2 and dc3 registers
   // ******************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dc2_vld <= 1'b0;
         dc3_vld <= 1'b0;
         err_dc2 <= '0;
         err_dc3 <= '0;
      end else begin
         dc2_vld <= dc1.ctl.valid;
         dc3_vld <= dc2_vld;
         err_dc2 <= err_dc1;
         err_dc3 <= err_dc2;
      end
   end

   always_ff @(posedge clk) begin
      if (dc1.ctl.valid) dc2_q <= dc1;
      if (dc2_vld) dc3_q <= dc2_q;
      if (dc2_vld) ld_data_dc3 <= ld_data_dc2;
   end

   always_comb begin
      dc2           = dc2_q;
      dc2.ctl.valid = dc2_vld;
      dc3           = dc3_q;
      dc3.ctl.valid = dc3_vld;
   end

   // ******************************************************************
   // Load data, forward merge then align and extend
   // ******************************************************************
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = fwd.hit[b] ? fwd.data[8*b +: 8] : dccm_rd_data[8*b +: 8];
      end
      shifted = merged >> {dc2.addr.f.byte_off, 3'b000};
      case (dc2.ctl.size)
         SIZE_BYTE: ld_data_dc2 = {{(XLEN-8){~dc2.ctl.unsign & shifted[7]}}, shifted[7:0]};
         SIZE_HALF: ld_data_dc2 = {{(XLEN-16){~dc2.ctl.unsign & shifted[15]}}, shifted[15:0]};
         default:   ld_data_dc2 = shifted;
      endcase
   end

   assign load_result.valid = dc3.ctl.valid & dc3.ctl.load;
   assign load_result.data  = ld_data_dc3;

   assign error_pkt        = err_dc3;
   assign misaligned_pulse = err_dc3.exc_valid & err_dc3.misaligned;   // Perf count

   // Erroring requests are dropped in dc1 and must not return data
   a_err_no_load: assert property (@(posedge clk) disable iff (!rst_n)
      !(error_pkt.exc_valid && load_result.valid))
      else $error("Load result and access error in the same cycle");

endmodule

/* verilog/lsu_stbuf.sv */
// Load/store unit store buffer with DCCM drain, byte forwarding and stall count
`timescale 1ns/1ps

module lsu_stbuf (
   input  logic                                clk,
   input  logic                                rst_n,
   input  lsu_pkg::lsu_stage_t                 dc1,
   input  lsu_pkg::lsu_stage_t                 dc2,
   input  lsu_pkg::lsu_stage_t                 dc3,
   output lsu_pkg::stbuf_fwd_t                 fwd,
   output logic                                wr_valid,
   output logic [lsu_pkg::DCCM_INDEX_BITS-1:0] wr_index,
   output logic [lsu_pkg::XLEN-1:0]            wr_data,
   output logic [3:0]                          wr_byteen,
   output logic                                stall,
   output logic                                empty
);
   import lsu_pkg::*;

   typedef struct packed {
      logic [DCCM_INDEX_BITS-1:0] index;
      logic [3:0]                 byteen;
      logic [XLEN-1:0]            data;
   } stbuf_entry_t;

   stbuf_entry_t               ent [STBUF_DEPTH];
   logic [STBUF_DEPTH-1:0]     vld;
   logic [STBUF_PTR_BITS-1:0]  head;     // Oldest entry
   logic [STBUF_PTR_BITS-1:0]  tail;     // Next free slot
   logic                       alloc;
   logic                       drain;
   logic                       full;
   logic [STBUF_PTR_BITS:0]    count;

   function automatic logic is_store(input lsu_stage_t s);
      return s.ctl.valid & s.ctl.store;
   endfunction

   // Lay newer bytes over what has been collected so far
   function automatic stbuf_fwd_t fwd_merge(input stbuf_fwd_t cur, input logic [3:0] be,
                                            input logic [XLEN-1:0] data);
      stbuf_fwd_t res;
      res = cur;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res.hit[b]         = 1'b1;
            res.data[8*b +: 8] = data[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign alloc = is_store(dc3);
   assign full  = &vld;
   assign empty = ~|vld;

   // Hold the drain while dc1 reads, so the read sees either memory or the buffer
   assign drain = vld[head] & ~(dc1.ctl.valid & dc1.ctl.load);

   // ******************************************************************
   // Allocation and drain
   // ******************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld  <= '0;
         head <= '0;
         tail <= '0;
      end else begin
         if (alloc) begin
            vld[tail] <= 1'b1;
            tail      <= tail + 1'b1;
         end
         if (drain) begin
            vld[head] <= 1'b0;
            head      <= head + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         ent[tail] <= '{index: dc3.addr.f.index, byteen: dc3.byteen, data: dc3.data};
      end
   end

   assign wr_valid  = drain;
   assign wr_index  = ent[head].index;
   assign wr_data   = ent[head].data;
   assign wr_byteen = ent[head].byteen;

   // ******************************************************************
   // Forwarding to the dc2 load, oldest first so the newest store wins
   // ******************************************************************
   always_comb begin : fwd_lookup
      logic [STBUF_PTR_BITS-1:0] ptr;
      fwd = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         ptr = head + STBUF_PTR_BITS'(i);
         if (vld[ptr] && (ent[ptr].index == dc2.addr.f.index)) begin
            fwd = fwd_merge(fwd, ent[ptr].byteen, ent[ptr].data);
         end
      end
      if (is_store(dc3) && (dc3.addr.f.index == dc2.addr.f.index)) begin
         fwd = fwd_merge(fwd, dc3.byteen, dc3.data);   // Not yet allocated
      end
      if (!(dc2.ctl.valid && dc2.ctl.load)) begin
         fwd.hit = '0;
      end
   end

   // Buffered plus in-flight stores
   always_comb begin
      count = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         count = count + {{STBUF_PTR_BITS{1'b0}}, vld[i]};
      end
      count = count + {{STBUF_PTR_BITS{1'b0}}, is_store(dc1)};
      count = count + {{STBUF_PTR_BITS{1'b0}}, is_store(dc2)};
      count = count + {{STBUF_PTR_BITS{1'b0}}, is_store(dc3)};
   end

   assign stall = (int'(count) >= STBUF_DEPTH - 1);   // One slot kept for a late store

   a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
      alloc |-> !full)
      else $error("Store buffer allocation while full");

endmodule

/* verilog/lsu_addr_gen.sv */
// Load/store dc1 stage, address generation with DCCM region and alignment checks
`timescale 1ns/1ps

module lsu_addr_gen (
   input  logic                    clk,
   input  logic                    rst_n,
   input  lsu_pkg::lsu_req_t       req,
   output lsu_pkg::lsu_stage_t     dc1,
   output lsu_pkg::lsu_error_pkt_t err_dc1
);
   import lsu_pkg::*;

   lsu_req_t   req_q;      // Request payload
   logic       req_vld;
   lsu_addr_u  addr;
   logic       in_dccm;
   logic       misaligned;
   logic       access;
   logic       err;
   logic [3:0] byteen;
   logic [XLEN-1:0] st_data;

   // ******************************************************************
   // Request register
   // ******************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_vld <= 1'b0;
      end else begin
         req_vld <= req.ctl.valid;
      end
   end

   always_ff @(posedge clk) begin
      req_q <= req;
   end

   // ******************************************************************
   // Address and checks
   // ******************************************************************
   assign addr.raw = req_q.base +
                     {{(XLEN-OFFSET_BITS){req_q.offset[OFFSET_BITS-1]}}, req_q.offset};

   assign in_dccm = (addr.f.tag == DCCM_BASE[XLEN-1 -: DCCM_TAG_BITS]);

   assign misaligned = ((req_q.ctl.size == SIZE_HALF) & addr.f.byte_off[0]) |
                       ((req_q.ctl.size == SIZE_WORD) & (|addr.f.byte_off));

   assign access = req_vld & (req_q.ctl.load | req_q.ctl.store);
   assign err    = access & (misaligned | ~in_dccm);

   // Byte lanes touched and store data replicated across them
   always_comb begin
      case (req_q.ctl.size)
         SIZE_BYTE: begin
            byteen  = 4'b0001 << addr.f.byte_off;
            st_data = {4{req_q.store_data[7:0]}};
         end
         SIZE_HALF: begin
            byteen  = 4'b0011 << addr.f.byte_off;
            st_data = {2{req_q.store_data[15:0]}};
         end
         default: begin
            byteen  = 4'b1111;
            st_data = req_q.store_data;
         end
      endcase
   end

   always_comb begin
      dc1           = '0;
      dc1.ctl       = req_q.ctl;
      dc1.ctl.valid = access & ~err;   // Errors never reach memory
      dc1.addr      = addr;
      dc1.byteen    = byteen;
      dc1.data      = st_data;
   end

   always_comb begin
      err_dc1.exc_valid  = err;
      err_dc1.is_store   = req_q.ctl.store;
      err_dc1.misaligned = misaligned;
      err_dc1.addr       = addr.raw;
   end

   // Requester contract, one access kind per strobe
   a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      req.ctl.valid |-> (req.ctl.load ^ req.ctl.store))
      else $error("LSU request with load and store both set or both clear");

endmodule

/* verilog/lsu_pkg.sv */
// Load/store unit package with sizing constants, access types and pipeline packets
package lsu_pkg;

   // ******************************************************************
   // Sizing
   // ******************************************************************
   localparam int XLEN                = 32;
   localparam logic [XLEN-1:0] DCCM_BASE = 32'hF004_0000;
   localparam int DCCM_INDEX_BITS     = 10;    // 1K words, 4 KiB
   localparam int DCCM_TAG_BITS       = 20;
   localparam int STBUF_DEPTH         = 4;
   localparam int STBUF_PTR_BITS      = 2;
   localparam int OFFSET_BITS         = 12;    // I/S-type immediate

   // ******************************************************************
   // Request and control
   // ******************************************************************
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } lsu_size_e;

   typedef struct packed {
      logic      valid;
      logic      load;
      logic      store;
      lsu_size_e size;
      logic      unsign;   // Zero-extend on load
   } lsu_ctl_t;

   typedef struct packed {
      lsu_ctl_t                ctl;
      logic [XLEN-1:0]         base;       // rs1
      logic [XLEN-1:0]         store_data; // rs2
      logic [OFFSET_BITS-1:0]  offset;
   } lsu_req_t;

   // Address word, raw or split into region tag, word index and byte lane
   typedef union packed {
      logic [XLEN-1:0] raw;
      struct packed {
         logic [DCCM_TAG_BITS-1:0]   tag;
         logic [DCCM_INDEX_BITS-1:0] index;
         logic [1:0]                 byte_off;
      } f;
   } lsu_addr_u;

   typedef struct packed {
      lsu_ctl_t        ctl;
      lsu_addr_u       addr;
      logic [3:0]      byteen;
      logic [XLEN-1:0] data;     // Store data already placed on its lanes
   } lsu_stage_t;

   // ******************************************************************
   // Store buffer, DCCM port and results
   // ******************************************************************
   typedef struct packed {
      logic [3:0]      hit;      // Per-byte forward valid
      logic [XLEN-1:0] data;
   } stbuf_fwd_t;

   typedef struct packed {
      logic                       rden;
      logic [DCCM_INDEX_BITS-1:0] rd_index;
      logic                       wren;
      logic [DCCM_INDEX_BITS-1:0] wr_index;
      logic [XLEN-1:0]            wr_data;
      logic [3:0]                 wr_byteen;
   } dccm_req_t;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] data;
   } lsu_result_t;

   typedef struct packed {
      logic            exc_valid;
      logic            is_store;
      logic            misaligned;  // Clear for a pure range error
      logic [XLEN-1:0] addr;
   } lsu_error_pkt_t;

endpackage
